// File: src/demodRegPkg.sv
/*
 * Demodulator register map
 * APB widths, register offsets, version word and counter type
 */
package demodRegPkg;

    //********************************************************************
    // Bus widths
    //********************************************************************

    // Byte address, one 32-bit word per register
    typedef logic [11:0] apbAddrT;
    typedef logic [31:0] apbDataT;

    // Free-running clock counter and its sampled copy
    typedef logic [31:0] clockCountT;

    //********************************************************************
    // Register offsets
    //********************************************************************

    localparam apbAddrT VERSION_ADDR = 12'h000;
    localparam apbAddrT CLOCK_ADDR   = 12'h004;
    localparam apbAddrT MODE_ADDR    = 12'h008;

    // Returned in the upper half word of VERSION_ADDR
    localparam logic [15:0] VERSION_NUMBER = 16'h0168;

endpackage

// File: src/demodSignalPkg.sv
/*
 * Demodulator signal definitions
 * Sample, symbol and DAC widths plus the demodulation mode encoding
 */
package demodSignalPkg;

    // Symbol and monitor samples, two's complement
    typedef logic signed [17:0] symSampleT;

    // Monitor DAC word
    typedef logic [13:0] dacWordT;

    // Monitor DAC channels
    localparam int NUM_DACS = 3;

    // Low sample bits dropped when forming a DAC word
    localparam int DAC_LSB_DROP = 4;

    // Demodulation mode, matches the legacy encoding
    typedef enum logic [4:0] {
        MODE_FM         = 5'd0,
        MODE_2FSK       = 5'd1,
        MODE_PCMTRELLIS = 5'd2,
        MODE_SOQPSK     = 5'd3,
        MODE_MULTIH     = 5'd4
    } demodModeT;

endpackage

// File: src/demodRegs.sv
/*
 * Demodulator control registers on an APB slave
 * Version word, restartable clock counter and demodulation mode
 */
module demodRegs (
    input  logic                      clk,
    input  logic                      clockCounterEn,
    input  demodRegPkg::apbAddrT      paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  demodRegPkg::apbDataT      pwdata,
    output demodRegPkg::apbDataT      prdata,
    output logic                      pready,
    output logic                      pslverr,
    output demodSignalPkg::demodModeT demodMode
);
    import demodRegPkg::*;
    import demodSignalPkg::*;

    logic       setupCycle;
    logic       accessCycle;
    logic       addrValid;
    logic       clockWrite;
    logic       clockSample;
    logic       modeWrite;
    clockCountT clockCounter;
    clockCountT clockHold;

    //********************************************************************
    // Address decode
    //********************************************************************

    assign setupCycle  = psel && !penable;
    assign accessCycle = psel && penable;
    assign addrValid   = (paddr == VERSION_ADDR) || (paddr == CLOCK_ADDR) ||
                         (paddr == MODE_ADDR);

    // Writes complete at the access cycle edge, no wait states
    assign clockWrite = accessCycle && pwrite && (paddr == CLOCK_ADDR);
    assign modeWrite  = accessCycle && pwrite && (paddr == MODE_ADDR);

    // Count is captured on the setup edge of any CLOCK_ADDR access
    assign clockSample = setupCycle && (paddr == CLOCK_ADDR);

    assign pready  = 1'b1;
    assign pslverr = accessCycle && !addrValid;

    //********************************************************************
    // Registers
    //********************************************************************

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            clockCounter <= '0;
            clockHold    <= '0;
            demodMode    <= MODE_FM;
        end else begin
            if (clockWrite) begin
                clockCounter <= '0;
            end else begin
                clockCounter <= clockCounter + clockCountT'(1);
            end
            if (clockSample) begin
                clockHold <= clockCounter;
            end
            // New mode reaches the stages in the cycle after the write
            if (modeWrite) begin
                demodMode <= demodModeT'(pwdata[$bits(demodModeT)-1:0]);
            end
        end
    end

    // Read data
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                VERSION_ADDR: prdata = {VERSION_NUMBER, 16'h0000};
                CLOCK_ADDR:   prdata = clockHold;
                MODE_ADDR:    prdata = apbDataT'(demodMode);
                default:      prdata = '0;
            endcase
        end
    end

    // Master must open every transfer with a setup cycle
    assert property (@(posedge clk) disable iff (clockCounterEn) penable |-> psel)
        else $error("APB penable high without psel");

endmodule

// File: src/symbolInputStage.sv
/*
 * Pipeline stage 1, registers the legacy and multi-h symbol streams
 * and drives the mode-gated symbol feed into the multi-h carrier loop
 */
module symbolInputStage (
    input  logic                      clk,
    input  logic                      clockCounterEn,
    input  demodSignalPkg::demodModeT demodMode,
    // Legacy demodulator
    input  logic                      legacySymEn, legacySym2xEn, legacyTrellisSync,
    input  demodSignalPkg::symSampleT iLegacySym, qLegacySym,
    input  logic                      iBit, qBit, bitsyncLock, carrierLock,
    // Multi-h carrier loop
    input  logic                      multihLoopEn, multihLoop2xEn,
    input  demodSignalPkg::symSampleT iMultihLoop, qMultihLoop,
    input  logic                      multihDemodLock,
    // DAC candidates
    input  logic                      legacyDacSync [demodSignalPkg::NUM_DACS],
    input  demodSignalPkg::symSampleT legacyDacData [demodSignalPkg::NUM_DACS],
    input  logic                      multihDacSync [demodSignalPkg::NUM_DACS],
    input  logic                      multihDacEn [demodSignalPkg::NUM_DACS],
    input  demodSignalPkg::symSampleT multihDacData [demodSignalPkg::NUM_DACS],
    // Registered copies
    output logic                      legacySymEnR, legacySym2xEnR, legacyTrellisSyncR,
    output demodSignalPkg::symSampleT iLegacySymR, qLegacySymR,
    output logic                      iBitR, qBitR, bitsyncLockR, carrierLockR,
    output logic                      multihLoopEnR, multihLoop2xEnR,
    output demodSignalPkg::symSampleT iMultihLoopR, qMultihLoopR,
    output logic                      multihDemodLockR,
    output logic                      legacyDacSyncR [demodSignalPkg::NUM_DACS],
    output demodSignalPkg::symSampleT legacyDacDataR [demodSignalPkg::NUM_DACS],
    output logic                      multihDacSyncR [demodSignalPkg::NUM_DACS],
    output logic                      multihDacEnR [demodSignalPkg::NUM_DACS],
    output demodSignalPkg::symSampleT multihDacDataR [demodSignalPkg::NUM_DACS],
    // Feed into the multi-h loop
    output logic                      multihSymEn, multihSym2xEn,
    output demodSignalPkg::symSampleT iMultihIn, qMultihIn
);
    import demodSignalPkg::*;

    logic multihMode;

    assign multihMode = (demodMode == MODE_MULTIH);

    // Strobes and locks
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            legacySymEnR       <= 1'b0;
            legacySym2xEnR     <= 1'b0;
            legacyTrellisSyncR <= 1'b0;
            bitsyncLockR       <= 1'b0;
            carrierLockR       <= 1'b0;
            multihLoopEnR      <= 1'b0;
            multihLoop2xEnR    <= 1'b0;
            multihDemodLockR   <= 1'b0;
            legacyDacSyncR     <= '{default: 1'b0};
            multihDacSyncR     <= '{default: 1'b0};
            multihDacEnR       <= '{default: 1'b0};
            multihSymEn        <= 1'b0;
            multihSym2xEn      <= 1'b0;
        end else begin
            legacySymEnR       <= legacySymEn;
            legacySym2xEnR     <= legacySym2xEn;
            legacyTrellisSyncR <= legacyTrellisSync;
            bitsyncLockR       <= bitsyncLock;
            carrierLockR       <= carrierLock;
            multihLoopEnR      <= multihLoopEn;
            multihLoop2xEnR    <= multihLoop2xEn;
            multihDemodLockR   <= multihDemodLock;
            legacyDacSyncR     <= legacyDacSync;
            multihDacSyncR     <= multihDacSync;
            multihDacEnR       <= multihDacEn;
            // Loop only sees symbol strobes in multi-h mode
            multihSymEn        <= legacyTrellisSync && multihMode;
            multihSym2xEn      <= legacySym2xEn && multihMode;
        end
    end

    // Samples and bits
    always_ff @(posedge clk) begin
        iLegacySymR    <= iLegacySym;
        qLegacySymR    <= qLegacySym;
        iBitR          <= iBit;
        qBitR          <= qBit;
        iMultihLoopR   <= iMultihLoop;
        qMultihLoopR   <= qMultihLoop;
        legacyDacDataR <= legacyDacData;
        multihDacDataR <= multihDacData;
        // Trellis samples go to the loop ungated
        iMultihIn      <= iLegacySym;
        qMultihIn      <= qLegacySym;
    end

endmodule

// File: src/modeSelectStage.sv
/*
 * Pipeline stage 2, picks trellis, data bit and lock outputs
 * from the legacy or multi-h source according to the mode
 */
module modeSelectStage (
    input  logic                      clk,
    input  logic                      clockCounterEn,
    input  demodSignalPkg::demodModeT demodMode,
    input  logic                      legacySymEnR, legacySym2xEnR, legacyTrellisSyncR,
    input  demodSignalPkg::symSampleT iLegacySymR, qLegacySymR,
    input  logic                      iBitR, qBitR, bitsyncLockR, carrierLockR,
    input  logic                      multihLoopEnR, multihLoop2xEnR,
    input  demodSignalPkg::symSampleT iMultihLoopR, qMultihLoopR,
    input  logic                      multihDemodLockR,
    output logic                      trellisSymEn, trellisSym2xEn,
    output demodSignalPkg::symSampleT iTrellis, qTrellis,
    output logic                      legacyBit,
    output logic                      iData, qData,
    output logic                      dataSymEn, dataSym2xEn,
    output logic                      bsyncNLock, demodNLock
);
    import demodSignalPkg::*;

    logic multihMode;
    logic fmModes;

    assign multihMode = (demodMode == MODE_MULTIH);
    // FSK style modes deliver iBit with the opposite sense
    assign fmModes    = (demodMode == MODE_FM) || (demodMode == MODE_2FSK);

    //********************************************************************
    // Strobes and lock indicators
    //********************************************************************

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            trellisSymEn   <= 1'b0;
            trellisSym2xEn <= 1'b0;
            dataSymEn      <= 1'b0;
            dataSym2xEn    <= 1'b0;
            bsyncNLock     <= 1'b1;
            demodNLock     <= 1'b1;
        end else begin
            trellisSymEn   <= multihMode ? multihLoopEnR : legacyTrellisSyncR;
            trellisSym2xEn <= multihMode ? multihLoop2xEnR : legacySym2xEnR;
            dataSymEn      <= legacySymEnR;
            dataSym2xEn    <= legacySym2xEnR;
            bsyncNLock     <= !bitsyncLockR;
            demodNLock     <= multihMode ? !multihDemodLockR : !carrierLockR;
        end
    end

    // Trellis samples and data bits
    always_ff @(posedge clk) begin
        iTrellis  <= multihMode ? iMultihLoopR : iLegacySymR;
        qTrellis  <= multihMode ? qMultihLoopR : qLegacySymR;
        legacyBit <= iBitR;
        iData     <= fmModes ? !iBitR : iBitR;
        qData     <= qBitR;
    end

    // Mode register must only ever hold a defined encoding
    assert property (@(posedge clk) disable iff (clockCounterEn)
        demodMode inside {MODE_FM, MODE_2FSK, MODE_PCMTRELLIS, MODE_SOQPSK, MODE_MULTIH})
        else $error("Undefined demodulation mode %0d", demodMode);

endmodule

// File: src/dacOutputStage.sv
/*
 * Pipeline stage 3, selects each monitor DAC source, truncates
 * the sample to a DAC word and holds it between sync strobes
 */
module dacOutputStage (
    input  logic                      clk,
    input  logic                      clockCounterEn,
    input  demodSignalPkg::demodModeT demodMode,
    input  logic                      legacyDacSyncR [demodSignalPkg::NUM_DACS],
    input  demodSignalPkg::symSampleT legacyDacDataR [demodSignalPkg::NUM_DACS],
    input  logic                      multihDacSyncR [demodSignalPkg::NUM_DACS],
    input  logic                      multihDacEnR [demodSignalPkg::NUM_DACS],
    input  demodSignalPkg::symSampleT multihDacDataR [demodSignalPkg::NUM_DACS],
    output logic                      dacSync [demodSignalPkg::NUM_DACS],
    output demodSignalPkg::dacWordT   dacData [demodSignalPkg::NUM_DACS]
);
    import demodSignalPkg::*;

    logic      multihMode;
    logic      useMultih [NUM_DACS];
    symSampleT selData [NUM_DACS];

    assign multihMode = (demodMode == MODE_MULTIH);

    // Multi-h drives a channel only when it claims it in multi-h mode
    always_comb begin
        for (int i = 0; i < NUM_DACS; i++) begin
            useMultih[i] = multihMode && multihDacEnR[i];
        end
    end

    //********************************************************************
    // Source select, then sync-enabled hold
    //********************************************************************

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_DACS; i++) begin
            selData[i] <= useMultih[i] ? multihDacDataR[i] : legacyDacDataR[i];
        end
    end

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dacSync <= '{default: 1'b0};
            dacData <= '{default: '0};
        end else begin
            for (int i = 0; i < NUM_DACS; i++) begin
                dacSync[i] <= useMultih[i] ? multihDacSyncR[i] : legacyDacSyncR[i];
                // Keep the top 14 bits of the sample
                if (dacSync[i]) begin
                    dacData[i] <= selData[i][DAC_LSB_DROP +: $bits(dacWordT)];
                end
            end
        end
    end

    // Word may only change two edges after the channel's selected stage-1 sync
    for (genvar i = 0; i < NUM_DACS; i++) begin : gHoldCheck
        assert property (@(posedge clk) disable iff (clockCounterEn)
            !$stable(dacData[i]) |->
                $past((multihMode && multihDacEnR[i]) ? multihDacSyncR[i]
                                                      : legacyDacSyncR[i], 2))
            else $error("DAC %0d word changed without a selected sync", i);
    end

endmodule

// File: src/demodOutputTop.sv
/*
 * Demodulator output and control section, register block
 * feeding the input, mode-select and DAC pipeline stages
 */
module demodOutputTop (
    input  logic                      clk,
    input  logic                      clockCounterEn,
    // APB
    input  demodRegPkg::apbAddrT      paddr,
    input  logic                      psel, penable, pwrite,
    input  demodRegPkg::apbDataT      pwdata,
    output demodRegPkg::apbDataT      prdata,
    output logic                      pready, pslverr,
    output demodSignalPkg::demodModeT demodMode,
    // Legacy demodulator
    input  logic                      legacySymEn, legacySym2xEn, legacyTrellisSync,
    input  demodSignalPkg::symSampleT iLegacySym, qLegacySym,
    input  logic                      iBit, qBit, bitsyncLock, carrierLock,
    // Multi-h carrier loop
    input  logic                      multihLoopEn, multihLoop2xEn,
    input  demodSignalPkg::symSampleT iMultihLoop, qMultihLoop,
    input  logic                      multihDemodLock,
    // DAC candidates
    input  logic                      legacyDacSync [demodSignalPkg::NUM_DACS],
    input  demodSignalPkg::symSampleT legacyDacData [demodSignalPkg::NUM_DACS],
    input  logic                      multihDacSync [demodSignalPkg::NUM_DACS],
    input  logic                      multihDacEn [demodSignalPkg::NUM_DACS],
    input  demodSignalPkg::symSampleT multihDacData [demodSignalPkg::NUM_DACS],
    // Outputs
    output logic                      multihSymEn, multihSym2xEn,
    output demodSignalPkg::symSampleT iMultihIn, qMultihIn,
    output logic                      trellisSymEn, trellisSym2xEn,
    output demodSignalPkg::symSampleT iTrellis, qTrellis,
    output logic                      legacyBit, iData, qData,
    output logic                      dataSymEn, dataSym2xEn,
    output logic                      bsyncNLock, demodNLock,
    output logic                      dacSync [demodSignalPkg::NUM_DACS],
    output demodSignalPkg::dacWordT   dacData [demodSignalPkg::NUM_DACS]
);
    import demodSignalPkg::*;

    // Stage 1 to stage 2
    logic      legacySymEnR, legacySym2xEnR, legacyTrellisSyncR;
    symSampleT iLegacySymR, qLegacySymR;
    logic      iBitR, qBitR, bitsyncLockR, carrierLockR;
    logic      multihLoopEnR, multihLoop2xEnR;
    symSampleT iMultihLoopR, qMultihLoopR;
    logic      multihDemodLockR;

    // Stage 1 to stage 3
    logic      legacyDacSyncR [NUM_DACS];
    symSampleT legacyDacDataR [NUM_DACS];
    logic      multihDacSyncR [NUM_DACS];
    logic      multihDacEnR [NUM_DACS];
    symSampleT multihDacDataR [NUM_DACS];

    demodRegs i_demodRegs (.*);

    symbolInputStage i_symbolInputStage (.*);

    modeSelectStage i_modeSelectStage (.*);

    dacOutputStage i_dacOutputStage (.*);

endmodule

// File: dv/demodOutputTb.sv
/*
 * Self-checking testbench for the demodulator output section
 * APB register checks plus a table of pipeline stimulus rows
 */
module demodOutputTb;
    import demodRegPkg::*;
    import demodSignalPkg::*;

    localparam int HALF_PERIOD    = 4;
    localparam int NUM_ROWS       = 10;
    localparam int CYCLES_PER_ROW = 12;
    // Four times the table budget, plus the register tests
    localparam int CYCLE_LIMIT    = 4 * NUM_ROWS * CYCLES_PER_ROW + 1520;

    typedef struct {
        string     name;
        demodModeT mode;
        logic [4:0] strobes;   // legacySymEn, legacySym2xEn, trellisSync, loopEn, loop2xEn
        logic [4:0] bits;      // iBit, qBit, bitsyncLock, carrierLock, multihDemodLock
        logic [2:0] dacEn;
        logic [2:0] legacySync;
        logic [2:0] multihSync;
        logic       expTrellisMultih;
        logic       expIDataInvert;
        logic       expFeedOn;
        logic [2:0] expDacMultih;
    } rowT;

    logic      clk;
    logic      clockCounterEn;
    apbAddrT   paddr;
    logic      psel, penable, pwrite;
    apbDataT   pwdata;
    apbDataT   prdata;
    logic      pready, pslverr;
    demodModeT demodMode;
    logic      legacySymEn, legacySym2xEn, legacyTrellisSync;
    symSampleT iLegacySym, qLegacySym;
    logic      iBit, qBit, bitsyncLock, carrierLock;
    logic      multihLoopEn, multihLoop2xEn;
    symSampleT iMultihLoop, qMultihLoop;
    logic      multihDemodLock;
    logic      legacyDacSync [NUM_DACS];
    symSampleT legacyDacData [NUM_DACS];
    logic      multihDacSync [NUM_DACS];
    logic      multihDacEn [NUM_DACS];
    symSampleT multihDacData [NUM_DACS];
    logic      multihSymEn, multihSym2xEn;
    symSampleT iMultihIn, qMultihIn;
    logic      trellisSymEn, trellisSym2xEn;
    symSampleT iTrellis, qTrellis;
    logic      legacyBit, iData, qData;
    logic      dataSymEn, dataSym2xEn;
    logic      bsyncNLock, demodNLock;
    logic      dacSync [NUM_DACS];
    dacWordT   dacData [NUM_DACS];

    rowT         rows [$];
    logic [31:0] lfsrState = 32'h278d5f18;
    dacWordT     expDac [NUM_DACS];
    int          errorCount;
    int          testErrors;
    int          passCount;
    int          failCount;
    int          cycleCount;

    demodOutputTop i_demodOutputTop (.*);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("ERROR: simulation did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //********************************************************************
    // Helpers
    //********************************************************************

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic stepLfsr();
        logic newBit;
        newBit = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], newBit};
        return newBit;
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], stepLfsr()};
        end
        return value;
    endfunction

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAIL %s %s expected 0x%0h actual 0x%0h",
                     testName, field, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic finishTest(input string testName);
        if (testErrors == 0) begin
            $display("test %s passed", testName);
            passCount++;
        end else begin
            $display("test %s failed with %0d mismatches", testName, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    // Called at a falling edge, returns at a falling edge
    task automatic apbWrite(input apbAddrT addr, input apbDataT data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        while (!pready) @(negedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input apbAddrT addr, output apbDataT data, output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
        end
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic idleInputs();
        {legacySymEn, legacySym2xEn, legacyTrellisSync, multihLoopEn, multihLoop2xEn} = '0;
        for (int i = 0; i < NUM_DACS; i++) begin
            legacyDacSync[i] = 1'b0;
            multihDacSync[i] = 1'b0;
        end
    endtask

    task automatic addRow(input string name, input demodModeT mode, input logic [4:0] strobes,
                          input logic [4:0] bits, input logic [2:0] dacEn,
                          input logic [2:0] legSync, input logic [2:0] mhSync,
                          input logic trMultih, input logic inv, input logic feed,
                          input logic [2:0] dacMultih);
        rowT row;
        row.name = name;
        row.mode = mode;
        row.strobes = strobes;
        row.bits = bits;
        row.dacEn = dacEn;
        row.legacySync = legSync;
        row.multihSync = mhSync;
        row.expTrellisMultih = trMultih;
        row.expIDataInvert = inv;
        row.expFeedOn = feed;
        row.expDacMultih = dacMultih;
        rows.push_back(row);
    endtask

    //********************************************************************
    // Table rows and their checks
    //********************************************************************

    task automatic runRow(input rowT row);
        logic       sync;
        logic       expSync [NUM_DACS];
        symSampleT  sel;
        symSampleT  iLegExp;
        symSampleT  qLegExp;
        symSampleT  iMhExp;
        symSampleT  qMhExp;
        logic [4:0] st;
        logic [4:0] bt;
        apbWrite(MODE_ADDR, apbDataT'(row.mode));
        iLegacySym  = symSampleT'(randomBits(18));
        qLegacySym  = symSampleT'(randomBits(18));
        iMultihLoop = symSampleT'(randomBits(18));
        qMultihLoop = symSampleT'(randomBits(18));
        iLegExp = iLegacySym;
        qLegExp = qLegacySym;
        iMhExp  = iMultihLoop;
        qMhExp  = qMultihLoop;
        st = row.strobes;
        bt = row.bits;
        {legacySymEn, legacySym2xEn, legacyTrellisSync, multihLoopEn, multihLoop2xEn} = st;
        {iBit, qBit, bitsyncLock, carrierLock, multihDemodLock} = bt;
        for (int i = 0; i < NUM_DACS; i++) begin
            legacyDacData[i] = symSampleT'(randomBits(18));
            multihDacData[i] = symSampleT'(randomBits(18));
            legacyDacSync[i] = row.legacySync[i];
            multihDacSync[i] = row.multihSync[i];
            multihDacEn[i]   = row.dacEn[i];
            sel  = row.expDacMultih[i] ? multihDacData[i] : legacyDacData[i];
            sync = row.expDacMultih[i] ? row.multihSync[i] : row.legacySync[i];
            expSync[i] = sync;
            if (sync) begin
                expDac[i] = sel[17:4];
            end
        end
        @(negedge clk);
        idleInputs();
        // Multi-h feed after one cycle
        checkValue(row.name, "multihSymEn", st[2] && row.expFeedOn, multihSymEn);
        checkValue(row.name, "multihSym2xEn", st[3] && row.expFeedOn, multihSym2xEn);
        checkValue(row.name, "iMultihIn", iLegExp, iMultihIn);
        checkValue(row.name, "qMultihIn", qLegExp, qMultihIn);
        @(negedge clk);
        checkValue(row.name, "trellisSymEn", row.expTrellisMultih ? st[1] : st[2], trellisSymEn);
        checkValue(row.name, "trellisSym2xEn", row.expTrellisMultih ? st[0] : st[3],
                   trellisSym2xEn);
        checkValue(row.name, "iTrellis", row.expTrellisMultih ? iMhExp : iLegExp, iTrellis);
        checkValue(row.name, "qTrellis", row.expTrellisMultih ? qMhExp : qLegExp, qTrellis);
        checkValue(row.name, "legacyBit", bt[4], legacyBit);
        checkValue(row.name, "iData", row.expIDataInvert ? !bt[4] : bt[4], iData);
        checkValue(row.name, "qData", bt[3], qData);
        checkValue(row.name, "dataSymEn", st[4], dataSymEn);
        checkValue(row.name, "dataSym2xEn", st[3], dataSym2xEn);
        checkValue(row.name, "bsyncNLock", !bt[2], bsyncNLock);
        checkValue(row.name, "demodNLock", row.expTrellisMultih ? !bt[0] : !bt[1], demodNLock);
        // Selected sync leaves the select register one cycle ahead of the word
        for (int i = 0; i < NUM_DACS; i++) begin
            checkValue(row.name, $sformatf("dacSync%0d", i), expSync[i], dacSync[i]);
        end
        @(negedge clk);
        for (int i = 0; i < NUM_DACS; i++) begin
            checkValue(row.name, $sformatf("dacData%0d", i), expDac[i], dacData[i]);
        end
        finishTest(row.name);
    endtask

    initial begin
        apbDataT rdata;
        logic    rerr;
        clockCounterEn = 1'b1;
        {paddr, psel, penable, pwrite, pwdata} = '0;
        iLegacySym = '0;
        qLegacySym = '0;
        iMultihLoop = '0;
        qMultihLoop = '0;
        {iBit, qBit, bitsyncLock, carrierLock, multihDemodLock} = '0;
        for (int i = 0; i < NUM_DACS; i++) begin
            multihDacEn[i]   = 1'b0;
            legacyDacData[i] = '0;
            multihDacData[i] = '0;
            expDac[i]        = '0;
        end
        idleInputs();
        repeat (4) @(negedge clk);
        clockCounterEn = 1'b0;
        @(negedge clk);

        checkValue("reset", "demodMode", MODE_FM, demodMode);
        checkValue("reset", "pready", 1'b1, pready);
        checkValue("reset", "trellisSymEn", 1'b0, trellisSymEn);
        checkValue("reset", "trellisSym2xEn", 1'b0, trellisSym2xEn);
        checkValue("reset", "dataSymEn", 1'b0, dataSymEn);
        checkValue("reset", "dataSym2xEn", 1'b0, dataSym2xEn);
        checkValue("reset", "multihSymEn", 1'b0, multihSymEn);
        checkValue("reset", "multihSym2xEn", 1'b0, multihSym2xEn);
        checkValue("reset", "bsyncNLock", 1'b1, bsyncNLock);
        checkValue("reset", "demodNLock", 1'b1, demodNLock);
        for (int i = 0; i < NUM_DACS; i++) begin
            checkValue("reset", $sformatf("dacSync%0d", i), 1'b0, dacSync[i]);
            checkValue("reset", $sformatf("dacData%0d", i), 32'h0, dacData[i]);
        end
        finishTest("reset");

        apbRead(VERSION_ADDR, rdata, rerr);
        checkValue("version", "prdata", 32'h0168_0000, rdata);
        finishTest("version");

        apbWrite(MODE_ADDR, apbDataT'(MODE_SOQPSK));
        apbRead(MODE_ADDR, rdata, rerr);
        checkValue("modeReadback", "prdata", MODE_SOQPSK, rdata);
        checkValue("modeReadback", "demodMode", MODE_SOQPSK, demodMode);
        finishTest("modeReadback");

        apbRead(12'h010, rdata, rerr);
        checkValue("unmapped", "pslverr", 1'b1, rerr);
        checkValue("unmapped", "prdata", 32'h0, rdata);
        finishTest("unmapped");

        // Seven idle edges then the setup edge, count reads N minus 1
        apbWrite(CLOCK_ADDR, 32'h0);
        repeat (7) @(negedge clk);
        apbRead(CLOCK_ADDR, rdata, rerr);
        checkValue("clockCounter", "prdata", 32'd7, rdata);
        finishTest("clockCounter");

        addRow("multihTrellis", MODE_MULTIH, 5'b10111, 5'b10101, 3'b011, 3'b111, 3'b111,
               1, 0, 1, 3'b011);
        addRow("pcmTrellis", MODE_PCMTRELLIS, 5'b01111, 5'b11110, 3'b111, 3'b111, 3'b000,
               0, 0, 0, 3'b000);
        addRow("soqpskTrellis", MODE_SOQPSK, 5'b11100, 5'b01011, 3'b000, 3'b101, 3'b010,
               0, 0, 0, 3'b000);
        addRow("fmData", MODE_FM, 5'b10010, 5'b10110, 3'b101, 3'b010, 3'b111, 0, 1, 0, 3'b000);
        addRow("fskData", MODE_2FSK, 5'b01100, 5'b00001, 3'b000, 3'b001, 3'b000,
               0, 1, 0, 3'b000);
        addRow("multihLock", MODE_MULTIH, 5'b00011, 5'b11100, 3'b100, 3'b000, 3'b100,
               1, 0, 1, 3'b100);
        addRow("dacHold", MODE_MULTIH, 5'b00000, 5'b00000, 3'b111, 3'b111, 3'b000,
               1, 0, 1, 3'b111);
        addRow("dacLegacyHold", MODE_PCMTRELLIS, 5'b11111, 5'b11111, 3'b111, 3'b000, 3'b111,
               0, 0, 0, 3'b000);
        addRow("multihMixed", MODE_MULTIH, 5'b11111, 5'b01010, 3'b010, 3'b101, 3'b010,
               1, 0, 1, 3'b010);
        addRow("soqpskFeedOff", MODE_SOQPSK, 5'b00110, 5'b10011, 3'b111, 3'b110, 3'b111,
               0, 0, 0, 3'b000);

        foreach (rows[r]) begin
            runRow(rows[r]);
        end

        $display("Tests passed %0d failed %0d", passCount, failCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim.f
src/demodRegPkg.sv
src/demodSignalPkg.sv
src/demodRegs.sv
src/symbolInputStage.sv
src/modeSelectStage.sv
src/dacOutputStage.sv
src/demodOutputTop.sv
dv/demodOutputTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = demodOutputTb
FILELIST  = sim.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
